/* rtl/aether_pkg.sv */
package aether_pkg;

  // ------------------------------------------------
  // Datapath widths and sizes
  // ------------------------------------------------
  localparam int DataWidth      = 8;   // Activation and weight bytes
  localparam int WordWidth      = 16;  // Host and memory word
  localparam int KernelTaps     = 9;   // 3x3 kernel
  localparam int MaxMatrixSize  = 16;  // Max columns per row
  localparam int MemDepth       = 256; // Activation memory words
  localparam int MemAddrBits    = 8;
  localparam int ResultAddrBits = 8;   // Up to 14x14 outputs

  // ------------------------------------------------
  // Host opcodes and state encodings
  // ------------------------------------------------
  typedef enum logic [3:0] {
    OP_NOP          = 4'd0,
    OP_SET_ADDR     = 4'd1, // param_2 is start address
    OP_SET_SIZE     = 4'd2, // param_2[4:0] is matrix size
    OP_LOAD_WEIGHTS = 4'd3, // 5 words from start address
    OP_RUN_CONV     = 4'd4,
    OP_READ_STATUS  = 4'd5,
    OP_READ_RESULT  = 4'd6, // param_2 is result index
    OP_WRITE_MEM    = 4'd7  // param_1 0 restarts at address 0
  } opcode_e;

  // Who consumes the current read burst
  typedef enum logic [1:0] {
    TGT_NONE    = 2'd0,
    TGT_WEIGHTS = 2'd1,
    TGT_CONV    = 2'd2
  } mem_target_e;

  typedef enum logic [1:0] {
    CS_IDLE = 2'd0,
    CS_RUN  = 2'd1,
    CS_DONE = 2'd2  // One cycle, gives the done strobe
  } conv_state_e;

endpackage

/* rtl/aether_if.sv */
`timescale 1ns/1ps

// Read burst stream from activation memory to the byte FIFO
interface mem_rd_if;
  import aether_pkg::*;

  logic                   start; // One-cycle request, latches addr and count
  logic [MemAddrBits-1:0] addr;  // First word
  logic [MemAddrBits-1:0] count; // Words in burst
  logic                   full;  // FIFO short of two free words
  logic [WordWidth-1:0]   data;
  logic                   valid; // One cycle after each read
  logic                   done;  // With the last valid word

  modport requester (
    output start, addr, count,
    input  done
  );

  modport memory (
    input  start, addr, count, full,
    output data, valid, done
  );

  modport sink (
    input  data, valid,
    output full
  );

endinterface

/* rtl/aether_engine_decoder.sv */
`timescale 1ns/1ps

module aether_engine_decoder (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  aether_pkg::opcode_e                   opcode_i,
  input  logic [3:0]                            param_1_i,
  input  logic [aether_pkg::WordWidth-1:0]      param_2_i,
  mem_rd_if.requester                           mem,
  output logic                                  wr_en_o,
  output logic                                  wr_first_o,
  output logic [aether_pkg::WordWidth-1:0]      wr_data_o,
  output logic                                  wgt_en_o,
  output logic                                  conv_en_o,
  input  logic                                  byte_valid_i,
  input  logic                                  wgt_full_i,   // Ninth tap stored
  output logic                                  conv_start_o,
  input  logic                                  conv_done_i,
  output logic [4:0]                            size_o,
  output logic [aether_pkg::ResultAddrBits-1:0] result_idx_o,
  input  logic [aether_pkg::WordWidth-1:0]      result_i,
  output logic [aether_pkg::WordWidth-1:0]      data_o,
  output logic                                  interrupt_o
);
  import aether_pkg::*;

  logic                   busy_q;
  logic                   res_valid_q;  // Results from a finished run
  logic                   rd_active_q;  // Burst still streaming
  mem_target_e            target_q;
  logic [MemAddrBits-1:0] start_addr_q;
  logic [4:0]             size_q;
  logic [9:0]             px_total;
  logic [MemAddrBits-1:0] conv_words;

  // Bytes per run, rounded up to whole words
  assign px_total   = 10'(size_q) * 10'(size_q);
  assign conv_words = MemAddrBits'((px_total + 10'd1) >> 1);

  // Host writes go straight to memory, 2 cycles after presentation
  assign wr_en_o      = (opcode_i == OP_WRITE_MEM) && !busy_q;
  assign wr_first_o   = (param_1_i == 4'd0);
  assign wr_data_o    = param_2_i;
  assign result_idx_o = param_2_i[ResultAddrBits-1:0];

  assign wgt_en_o     = byte_valid_i && (target_q == TGT_WEIGHTS);
  assign conv_en_o    = byte_valid_i && (target_q == TGT_CONV);
  assign size_o       = size_q;
  assign interrupt_o  = busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_q       <= 1'b0;
      res_valid_q  <= 1'b0;
      rd_active_q  <= 1'b0;
      target_q     <= TGT_NONE;
      start_addr_q <= '0;
      size_q       <= 5'd3;
      data_o       <= '0;
      conv_start_o <= 1'b0;
      mem.start    <= 1'b0;
      mem.addr     <= '0;
      mem.count    <= '0;
    end
    else
    begin
      mem.start    <= 1'b0;
      conv_start_o <= 1'b0;
      if (mem.start)
        rd_active_q <= 1'b1;
      else if (mem.done)
        rd_active_q <= 1'b0;

      // ------------------------------------------------
      // End of load or run
      // ------------------------------------------------
      if ((target_q == TGT_WEIGHTS) && wgt_full_i)
      begin
        busy_q   <= 1'b0;
        target_q <= TGT_NONE;
      end
      if ((target_q == TGT_CONV) && conv_done_i)
      begin
        busy_q      <= 1'b0;
        target_q    <= TGT_NONE;
        res_valid_q <= 1'b1;
      end

      // Reads are served even while busy
      case (opcode_i)
        OP_READ_STATUS: data_o <= {3'b0, size_q, 5'b0, rd_active_q, res_valid_q, busy_q};
        OP_READ_RESULT: data_o <= result_i;
        default: ;
      endcase

      if (!busy_q)
      begin
        case (opcode_i)
          OP_SET_ADDR: start_addr_q <= param_2_i[MemAddrBits-1:0];
          OP_SET_SIZE:
            if ((param_2_i[4:0] >= 5'd3) && (param_2_i[4:0] <= 5'(MaxMatrixSize)))
              size_q <= param_2_i[4:0]; // Out of range sizes dropped
          OP_LOAD_WEIGHTS:
          begin
            mem.start <= 1'b1;
            mem.addr  <= start_addr_q;
            mem.count <= MemAddrBits'((KernelTaps + 1) / 2); // 9 bytes in 5 words
            target_q  <= TGT_WEIGHTS;
            busy_q    <= 1'b1;
          end
          OP_RUN_CONV:
          begin
            mem.start    <= 1'b1;
            mem.addr     <= start_addr_q;
            mem.count    <= conv_words;
            conv_start_o <= 1'b1;
            target_q     <= TGT_CONV;
            busy_q       <= 1'b1;
            res_valid_q  <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* rtl/aether_engine_mem.sv */
`timescale 1ns/1ps

module aether_engine_mem (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             wr_en_i,
  input  logic                             wr_first_i, // Restart at address 0
  input  logic [aether_pkg::WordWidth-1:0] wr_data_i,
  mem_rd_if.memory                         mem
);
  import aether_pkg::*;

  logic [WordWidth-1:0]   ram [MemDepth];
  logic [MemAddrBits-1:0] wr_ptr_q;
  logic [MemAddrBits-1:0] waddr;
  logic [MemAddrBits-1:0] rd_addr_q;
  logic [MemAddrBits-1:0] remain_q;  // Words left in burst
  logic                   rd_fire;

  assign waddr   = wr_first_i ? '0 : wr_ptr_q;
  assign rd_fire = (remain_q != '0) && !mem.full; // Stall on full FIFO

  // ------------------------------------------------
  // Storage, host write and read data
  // ------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      ram[waddr] <= wr_data_i;
    if (rd_fire)
      mem.data <= ram[rd_addr_q];
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      wr_ptr_q <= '0;
    else if (wr_en_i)
      wr_ptr_q <= waddr + 1'b1; // Auto increment
  end

  // ------------------------------------------------
  // Burst reader
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rd_addr_q <= '0;
      remain_q  <= '0;
      mem.valid <= 1'b0;
      mem.done  <= 1'b0;
    end
    else
    begin
      mem.valid <= rd_fire;
      mem.done  <= rd_fire && (remain_q == MemAddrBits'(1));
      if (mem.start)
      begin
        rd_addr_q <= mem.addr;
        remain_q  <= mem.count;
      end
      else if (rd_fire)
      begin
        rd_addr_q <= rd_addr_q + 1'b1;
        remain_q  <= remain_q - 1'b1;
      end
    end
  end

endmodule

/* rtl/width_fifo.sv */
`timescale 1ns/1ps

module width_fifo (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             flush_i,
  mem_rd_if.sink                           mem,
  output logic [aether_pkg::DataWidth-1:0] byte_o,
  output logic                             byte_valid_o
);
  import aether_pkg::*;

  logic [WordWidth-1:0] buf_q [4]; // 4 words
  logic [1:0]           wr_ptr_q;
  logic [1:0]           rd_ptr_q;
  logic                 hi_q;      // Low byte already sent
  logic [2:0]           count_q;   // Words held
  logic                 pop_word;

  assign byte_valid_o = (count_q != 3'd0);
  assign byte_o   = hi_q ? buf_q[rd_ptr_q][WordWidth-1:DataWidth]
                         : buf_q[rd_ptr_q][DataWidth-1:0];
  assign pop_word = byte_valid_o && hi_q;   // High byte leaves, word freed
  assign mem.full = (count_q >= 3'd3);      // Room for the read in flight

  always_ff @(posedge clk_i)
  begin
    if (mem.valid)
      buf_q[wr_ptr_q] <= mem.data;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      hi_q     <= 1'b0;
      count_q  <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      hi_q     <= 1'b0;
      count_q  <= '0;
    end
    else
    begin
      if (mem.valid)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (byte_valid_o)
        hi_q <= !hi_q;        // Pop every cycle not empty
      if (pop_word)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + {2'b0, mem.valid} - {2'b0, pop_word};
    end
  end

endmodule

/* rtl/conv_weight_store.sv */
`timescale 1ns/1ps

module conv_weight_store (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic                                    shift_i,
  input  logic [aether_pkg::DataWidth-1:0]        byte_i,
  output logic signed [aether_pkg::DataWidth-1:0] weights_o [aether_pkg::KernelTaps],
  output logic                                    loaded_o   // Ninth tap in
);
  import aether_pkg::*;

  logic [DataWidth-1:0] taps_q [KernelTaps];
  logic [3:0]           cnt_q;  // Bytes seen in this burst
  logic                 take;

  // Tenth byte of the burst is the unused high byte
  assign take = shift_i && (cnt_q < 4'(KernelTaps));

  // New bytes enter at the top, first byte ends at tap 0
  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      for (int i = 0; i < KernelTaps - 1; i++)
        taps_q[i] <= taps_q[i+1];
      taps_q[KernelTaps-1] <= byte_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt_q    <= '0;
      loaded_o <= 1'b0;
    end
    else
    begin
      loaded_o <= take && (cnt_q == 4'(KernelTaps - 1));
      if (shift_i)
        cnt_q <= (cnt_q == 4'(KernelTaps)) ? 4'd0 : cnt_q + 4'd1; // Ready for next load
    end
  end

  always_comb
  begin
    for (int i = 0; i < KernelTaps; i++)
      weights_o[i] = $signed(taps_q[i]);
  end

endmodule

/* rtl/conv_engine.sv */
`timescale 1ns/1ps

module conv_engine (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic                                    start_i,
  input  logic [4:0]                              size_i,
  input  logic                                    pixel_valid_i,
  input  logic signed [aether_pkg::DataWidth-1:0] pixel_i,
  input  logic signed [aether_pkg::DataWidth-1:0] weights_i [aether_pkg::KernelTaps],
  input  logic [aether_pkg::ResultAddrBits-1:0]   result_idx_i,
  output logic [aether_pkg::WordWidth-1:0]        result_o,
  output logic                                    done_o
);
  import aether_pkg::*;

  conv_state_e                 state_q;
  logic [4:0]                  row_q;
  logic [4:0]                  col_q;
  logic                        take;
  logic signed [DataWidth-1:0] lb_top_q [MaxMatrixSize]; // Two rows back
  logic signed [DataWidth-1:0] lb_mid_q [MaxMatrixSize]; // One row back
  logic signed [DataWidth-1:0] win_q [3][3];             // [0][0] top left
  logic                        win_valid_q;
  logic                        win_last_q;
  logic [ResultAddrBits-1:0]   out_idx_q;
  logic [WordWidth-1:0]        result_mem [2**ResultAddrBits];
  logic signed [WordWidth-1:0] sum;

  // Padding byte past the last row is dropped
  assign take     = (state_q == CS_RUN) && pixel_valid_i && (row_q != size_i);
  assign done_o   = (state_q == CS_DONE);
  assign result_o = result_mem[result_idx_i];

  // ------------------------------------------------
  // Line buffers, window and result write
  // ------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      lb_top_q[col_q[3:0]] <= lb_mid_q[col_q[3:0]];
      lb_mid_q[col_q[3:0]] <= pixel_i;
      for (int i = 0; i < 3; i++)
      begin
        win_q[i][0] <= win_q[i][1];
        win_q[i][1] <= win_q[i][2];
      end
      win_q[0][2] <= lb_top_q[col_q[3:0]];
      win_q[1][2] <= lb_mid_q[col_q[3:0]];
      win_q[2][2] <= pixel_i;
    end
    if (win_valid_q)
      result_mem[out_idx_q] <= sum;
  end

  // 16-bit wrapping MAC over the window
  always_comb
  begin
    sum = '0;
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
        sum = sum + win_q[i][j] * weights_i[3*i+j];
  end

  // ------------------------------------------------
  // Position tracking and FSM
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q     <= CS_IDLE;
      row_q       <= '0;
      col_q       <= '0;
      win_valid_q <= 1'b0;
      win_last_q  <= 1'b0;
      out_idx_q   <= '0;
    end
    else
    begin
      win_valid_q <= take && (row_q >= 5'd2) && (col_q >= 5'd2); // Full window
      win_last_q  <= take && (row_q == size_i - 5'd1) && (col_q == size_i - 5'd1);
      if (start_i)
      begin
        state_q   <= CS_RUN;
        row_q     <= '0;
        col_q     <= '0;
        out_idx_q <= '0;
      end
      else
      begin
        if (take)
        begin
          if (col_q == size_i - 5'd1)
          begin
            col_q <= '0;
            row_q <= row_q + 5'd1;
          end
          else
            col_q <= col_q + 5'd1;
        end
        if (win_valid_q)
          out_idx_q <= out_idx_q + 1'b1;  // Row-major output order
        if ((state_q == CS_RUN) && win_valid_q && win_last_q)
          state_q <= CS_DONE;             // Last result written now
        else if (state_q == CS_DONE)
          state_q <= CS_IDLE;
      end
    end
  end

endmodule

/* rtl/aether_engine.sv */
`timescale 1ns/1ps

module aether_engine (
  input  logic        clk_i,         // Core clock
  input  logic        arst_n_i,
  input  logic [3:0]  instruction_i, // Opcode
  input  logic [3:0]  param_1_i,
  input  logic [15:0] param_2_i,
  output logic [15:0] data_o,        // Status or result word
  output logic        interrupt_o    // Busy, only reads accepted
);
  import aether_pkg::*;

  // ------------------------------------------------
  // Current command
  // ------------------------------------------------
  opcode_e                     cmd_op_q;
  logic [3:0]                  cmd_p1_q;
  logic [WordWidth-1:0]        cmd_p2_q;

  logic                        wr_en;
  logic                        wr_first;
  logic [WordWidth-1:0]        wr_data;
  logic [DataWidth-1:0]        fifo_byte;
  logic                        byte_valid;
  logic                        wgt_en;     // Byte goes to weight store
  logic                        conv_en;    // Byte goes to engine
  logic                        wgt_loaded;
  logic                        conv_start;
  logic                        conv_done;
  logic [4:0]                  size;
  logic [ResultAddrBits-1:0]   result_idx;
  logic [WordWidth-1:0]        result;
  logic signed [DataWidth-1:0] weights [KernelTaps];

  mem_rd_if rd_bus ();

  // One flop stage on the host command
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cmd_op_q <= OP_NOP;
      cmd_p1_q <= '0;
      cmd_p2_q <= '0;
    end
    else
    begin
      cmd_op_q <= opcode_e'(instruction_i);
      cmd_p1_q <= param_1_i;
      cmd_p2_q <= param_2_i;
    end
  end

  // ------------------------------------------------
  // Blocks
  // ------------------------------------------------
  aether_engine_decoder u_decoder (
    .clk_i, .arst_n_i,
    .opcode_i(cmd_op_q), .param_1_i(cmd_p1_q), .param_2_i(cmd_p2_q),
    .mem(rd_bus.requester),
    .wr_en_o(wr_en), .wr_first_o(wr_first), .wr_data_o(wr_data),
    .wgt_en_o(wgt_en), .conv_en_o(conv_en), .byte_valid_i(byte_valid),
    .wgt_full_i(wgt_loaded),
    .conv_start_o(conv_start), .conv_done_i(conv_done),
    .size_o(size), .result_idx_o(result_idx), .result_i(result),
    .data_o, .interrupt_o
  );

  aether_engine_mem u_mem (
    .clk_i, .arst_n_i,
    .wr_en_i(wr_en), .wr_first_i(wr_first), .wr_data_i(wr_data),
    .mem(rd_bus.memory)
  );

  width_fifo u_fifo (
    .clk_i, .arst_n_i,
    .flush_i(rd_bus.start), // Drop leftovers at each burst
    .mem(rd_bus.sink),
    .byte_o(fifo_byte), .byte_valid_o(byte_valid)
  );

  conv_weight_store u_wgt (
    .clk_i, .arst_n_i,
    .shift_i(wgt_en), .byte_i(fifo_byte),
    .weights_o(weights), .loaded_o(wgt_loaded)
  );

  conv_engine u_conv (
    .clk_i, .arst_n_i,
    .start_i(conv_start), .size_i(size),
    .pixel_valid_i(conv_en), .pixel_i(fifo_byte), .weights_i(weights),
    .result_idx_i(result_idx), .result_o(result), .done_o(conv_done)
  );

endmodule

/* test/aether_engine_asserts.sv */
`timescale 1ns/1ps

module aether_engine_asserts (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic [3:0]  instruction_i,
  input logic [15:0] data_o,
  input logic        interrupt_o
);
  import aether_pkg::*;

  int          n_reset = 0;
  int          n_rise  = 0;
  int          n_cause = 0;
  int          n_data  = 0;
  int          n_bound = 0;
  int          fail_cnt;      // All failures, summed
  logic [11:0] busy_cnt;      // Consecutive busy cycles

  assign fail_cnt = n_reset + n_rise + n_cause + n_data + n_bound;

  function automatic logic is_work(input logic [3:0] op);
    return (op == OP_LOAD_WEIGHTS) || (op == OP_RUN_CONV);
  endfunction

  function automatic logic is_read(input logic [3:0] op);
    return (op == OP_READ_STATUS) || (op == OP_READ_RESULT);
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      busy_cnt <= '0;
    else
      busy_cnt <= interrupt_o ? busy_cnt + 12'd1 : 12'd0;
  end

  // ------------------------------------------------
  // Port properties
  // ------------------------------------------------
  reset_quiet: assert property (@(posedge clk_i)
    (!arst_n_i || !$past(arst_n_i)) |-> (!interrupt_o && (data_o == 16'd0)))
  else
  begin
    n_reset++;
    $error("interrupt_o or data_o not zero around reset");
  end

  // Load or run taken while idle
  busy_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (is_work($past(instruction_i, 2)) && !$past(interrupt_o)) |-> interrupt_o)
  else
  begin
    n_rise++;
    $error("interrupt_o did not rise 2 cycles after load or run");
  end

  rise_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(interrupt_o) |-> is_work($past(instruction_i, 2)))
  else
  begin
    n_cause++;
    $error("interrupt_o rose without a load or run");
  end

  data_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$stable(data_o) |-> is_read($past(instruction_i, 2)))   // Holds between reads
  else
  begin
    n_data++;
    $error("data_o changed without a read 2 cycles earlier");
  end

  // Trips once when a busy stretch reaches the limit
  busy_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_cnt != 12'd2000)
  else
  begin
    n_bound++;
    $error("interrupt_o stuck high");
  end

endmodule

bind aether_engine aether_engine_asserts u_asserts (
  .clk_i(clk_i),
  .arst_n_i(arst_n_i),
  .instruction_i(instruction_i),
  .data_o(data_o),
  .interrupt_o(interrupt_o)
);

/* test/aether_engine_tb.sv */
`timescale 1ns/1ps

module aether_engine_tb;
  import aether_pkg::*;

  logic        clk_i;
  logic        arst_n_i;
  logic [3:0]  instruction_i;
  logic [3:0]  param_1_i;
  logic [15:0] param_2_i;
  logic [15:0] data_o;
  logic        interrupt_o;

  logic [15:0] lfsr_q;
  logic [7:0]  mem_b [512]; // Byte image, kernel at 0, matrix at byte 16
  int          err_cnt;
  int          chk_cnt;
  int          test_err;    // Counts at start of current test
  int          test_chk;

  aether_engine dut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .instruction_i(instruction_i), .param_1_i(param_1_i), .param_2_i(param_2_i),
    .data_o(data_o), .interrupt_o(interrupt_o)
  );

  always #2 clk_i = !clk_i;

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      b      = {b[6:0], lfsr_q[0]};
    end
    return b;
  endfunction

  // One command for one cycle, then NOP
  task automatic send_cmd(input opcode_e op, input logic [3:0] p1, input logic [15:0] p2);
    @(posedge clk_i);
    instruction_i <= op;
    param_1_i     <= p1;
    param_2_i     <= p2;
    @(posedge clk_i);
    instruction_i <= OP_NOP;
  endtask

  // data_o updates 2 edges after presentation
  task automatic read_word(input opcode_e op, input logic [15:0] p2, output logic [15:0] val);
    send_cmd(op, 4'd0, p2);
    @(posedge clk_i);
    @(negedge clk_i);   // Stable mid cycle
    val = data_o;
  endtask

  task automatic wait_level(input logic lvl, input int limit, input string what);
    int n;
    n = 0;
    while ((interrupt_o !== lvl) && (n < limit))
    begin
      @(negedge clk_i);
      n++;
    end
    if (interrupt_o !== lvl)
    begin
      err_cnt++;
      $display("Timeout: interrupt_o never reached %0b during %s", lvl, what);
    end
  endtask

  task automatic run_busy(input opcode_e op);
    send_cmd(op, 4'd0, 16'd0);
    wait_level(1'b1, 8, "busy start");
    wait_level(1'b0, 4000, "busy end");
  endtask

  task automatic fill_image(input int n, input bit identity);
    for (int i = 0; i < 512; i++)
      mem_b[i] = 8'd0;
    for (int k = 0; k < KernelTaps; k++)
      mem_b[k] = identity ? ((k == 4) ? 8'd1 : 8'd0) : rand_byte();
    for (int i = 0; i < n * n; i++)
      mem_b[16 + i] = identity ? 8'(i * 37 + 3) : rand_byte();
  endtask

  // Low byte first in each word
  task automatic write_image(input int n);
    int words;
    words = (16 + n * n + 1) / 2;
    for (int w = 0; w < words; w++)
      send_cmd(OP_WRITE_MEM, (w == 0) ? 4'd0 : 4'd1, {mem_b[2*w+1], mem_b[2*w]});
  endtask

  task automatic load_and_run(input int n);
    send_cmd(OP_SET_SIZE, 4'd0, 16'(n));
    send_cmd(OP_SET_ADDR, 4'd0, 16'd0);
    run_busy(OP_LOAD_WEIGHTS);
    send_cmd(OP_SET_ADDR, 4'd0, 16'd8); // Matrix at word 8
    run_busy(OP_RUN_CONV);
  endtask

  // ------------------------------------------------
  // Reference model and checks
  // ------------------------------------------------
  function automatic logic [15:0] conv_ref(input int n, input int idx);
    int r0;
    int c0;
    int acc;
    r0  = idx / (n - 2);
    c0  = idx % (n - 2);
    acc = 0;
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
        acc += int'($signed(mem_b[16 + (r0 + i) * n + c0 + j])) * int'($signed(mem_b[3*i + j]));
    return acc[15:0];     // Wraps like the hardware sum
  endfunction

  task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
    chk_cnt++;
    assert (got == exp)
    else
    begin
      err_cnt++;
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_results(input int n);
    logic [15:0] val;
    for (int idx = 0; idx < (n - 2) * (n - 2); idx++)
    begin
      read_word(OP_READ_RESULT, 16'(idx), val);
      check_word(val, conv_ref(n, idx), $sformatf("result %0d of %0dx%0d", idx, n, n));
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, chk_cnt - test_chk, err_cnt - test_err);
    test_chk = chk_cnt;
    test_err = err_cnt;
  endtask

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial
  begin
    logic [15:0] val;
    logic [7:0]  p;
    clk_i         = 1'b0;
    arst_n_i      = 1'b0;
    instruction_i = 4'd0;
    param_1_i     = 4'd0;
    param_2_i     = 16'd0;
    lfsr_q        = 16'd25;
    err_cnt       = 0;
    chk_cnt       = 0;
    test_err      = 0;
    test_chk      = 0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;

    read_word(OP_READ_STATUS, 16'd0, val);
    check_word(val, 16'h0300, "status after reset"); // Size 3, idle
    end_test("1 reset status");

    fill_image(4, 1'b1);
    write_image(4);
    load_and_run(4);
    for (int idx = 0; idx < 4; idx++)
    begin
      read_word(OP_READ_RESULT, 16'(idx), val);
      p = mem_b[16 + (idx / 2 + 1) * 4 + idx % 2 + 1]; // Inner pixel
      check_word(val, {{8{p[7]}}, p}, $sformatf("identity result %0d", idx));
    end
    end_test("2 identity kernel");

    fill_image(7, 1'b0);
    write_image(7);
    load_and_run(7);
    check_results(7);
    read_word(OP_READ_STATUS, 16'd0, val);
    check_word(val, 16'h0702, "status after run");
    end_test("3 random 7x7");

    // Size and write must both bounce while busy
    send_cmd(OP_RUN_CONV, 4'd0, 16'd0);
    wait_level(1'b1, 8, "run start");
    read_word(OP_READ_STATUS, 16'd0, val);
    check_word({15'd0, val[0]}, 16'd1, "busy bit during run");
    send_cmd(OP_SET_SIZE, 4'd0, 16'd5);
    send_cmd(OP_WRITE_MEM, 4'd0, 16'hdead); // Would overwrite kernel word 0
    wait_level(1'b0, 4000, "run end");
    read_word(OP_READ_STATUS, 16'd0, val);
    check_word(val, 16'h0702, "status after rejected commands");
    load_and_run(7);
    check_results(7);
    end_test("4 busy rejection");

    fill_image(16, 1'b0);
    write_image(16);
    load_and_run(16);
    check_results(16);
    end_test("5 full size 16x16");

    err_cnt = err_cnt + dut.u_asserts.fail_cnt;
    $display("Checks %0d, errors %0d, assertion failures %0d",
             chk_cnt, err_cnt, dut.u_asserts.fail_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* filelist.f */
rtl/aether_pkg.sv
rtl/aether_if.sv
rtl/aether_engine_decoder.sv
rtl/aether_engine_mem.sv
rtl/width_fifo.sv
rtl/conv_weight_store.sv
rtl/conv_engine.sv
rtl/aether_engine.sv
test/aether_engine_asserts.sv
test/aether_engine_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module aether_engine_tb \
  -f filelist.f -o aether_engine_sim

out=$(./obj_dir/aether_engine_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "No errors"
